// ==== axi_wr_ctrl.sv ====
//**************************************************************************
// AXI4 write slave handshake controller
// AW/W/B sequencing with a busy wait while a downstream FIFO is full
// burst field capture, channel id and write response
//**************************************************************************

`timescale 1ns/1ps

module axi_wr_ctrl
    import axi_wr_pkg::*;
(
    input  logic              clk_sys,
    input  logic              rst,
    // AW channel
    input  logic              awvalid,
    output logic              awready,
    input  logic [ID_W-1:0]   awid,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [BLEN_W-1:0] awlen,
    input  logic [SIZE_W-1:0] awsize,
    // W channel handshake
    input  logic              wvalid,
    output logic              wready,
    input  logic              wlast,
    // B channel
    output logic              bvalid,
    input  logic              bready,
    output logic [ID_W-1:0]   bid,
    output logic [1:0]        bresp,
    // downstream FIFO status
    input  logic              pkt_full,
    input  logic              cmd_full,
    // to the packing stage
    output logic              beat_fire,
    output logic              beat_last,
    output logic [CHAN_W-1:0] chan,
    burst_info_if.master      info
);

    wr_state_e         state;
    wr_state_e         state_nxt;
    logic              aw_hs;
    logic              w_hs;
    logic              b_hs;
    logic              fifo_full;
    logic              fire_q;
    logic [ID_W-1:0]   id_q;
    logic [BLEN_W-1:0] blen_q;
    logic [SIZE_W-1:0] size_q;
    logic [ADDR_W-1:0] addr_q;

    assign aw_hs     = awvalid && awready;
    assign w_hs      = wvalid && wready;
    assign b_hs      = bvalid && bready;
    assign fifo_full = pkt_full || cmd_full;

    //**********************************************************************
    // state machine
    //**********************************************************************
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    state_nxt = RECV;
                end else if (fifo_full) begin
                    state_nxt = BUSY;
                end
            end
            RECV: begin
                if (w_hs && wlast) begin
                    state_nxt = RESP;
                end
            end
            RESP: begin
                // full flags are looked at only between bursts
                if (b_hs) begin
                    state_nxt = fifo_full ? BUSY : IDLE;
                end
            end
            BUSY: begin
                if (!fifo_full) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // ready/valid follow the state one edge behind, awready drops at once
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            awready   <= 1'b1;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            beat_fire <= 1'b0;
            beat_last <= 1'b0;
            fire_q    <= 1'b0;
        end else begin
            state     <= state_nxt;
            awready   <= (state_nxt == IDLE);
            wready    <= (state == RECV) && (state_nxt == RECV);
            bvalid    <= (state == RESP) && (state_nxt == RESP);
            beat_fire <= w_hs;
            beat_last <= w_hs && wlast;
            fire_q    <= aw_hs;
        end
    end

    //**********************************************************************
    // burst fields
    //**********************************************************************
    always_ff @(posedge clk_sys) begin
        if (aw_hs) begin
            id_q   <= awid;
            blen_q <= awlen;
            size_q <= awsize;
            addr_q <= awaddr;
            chan   <= awaddr[CHAN_W-1:0];
        end
    end

    assign info.fire = fire_q;
    assign info.id   = id_q;
    assign info.blen = blen_q;
    assign info.size = size_q;
    assign info.addr = addr_q;

    assign bid   = id_q;
    assign bresp = RESP_OKAY;

endmodule

// ==== axi_wr_pkg.sv ====
//**************************************************************************
// shared definitions for the AXI4 write to packet FIFO bridge
// AXI field widths, channel id and packet length widths
// controller state encoding and the command FIFO word
//**************************************************************************

package axi_wr_pkg;

    // AXI field widths
    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int BLEN_W = 8;
    localparam int SIZE_W = 3;

    // low address bits that select the channel
    localparam int CHAN_W = 4;

    // packet length in bytes, carried in the command word
    localparam int PKT_LEN_W = 16;

    // write response code, only OKAY is ever returned
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // write controller states
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RECV = 2'b01,
        RESP = 2'b10,
        BUSY = 2'b11
    } wr_state_e;

    // command FIFO word, one per burst
    typedef struct packed {
        logic [ID_W-1:0]      id;
        logic [BLEN_W-1:0]    blen;
        logic [SIZE_W-1:0]    size;
        logic [ADDR_W-1:0]    addr;
        logic [PKT_LEN_W-1:0] pkt_len;
    } pkt_cmd_t;

endpackage

// ==== axi_wr_pkt_top.sv ====
//**************************************************************************
// AXI4 write slave to packet FIFO bridge, top level
// handshake controller, beat packing and command generation
//**************************************************************************

`timescale 1ns/1ps

module axi_wr_pkt_top
    import axi_wr_pkg::*;
#(
    parameter int DATA_BYTES = 8
) (
    input  logic                          clk_sys,
    input  logic                          rst,
    // AW channel
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [ID_W-1:0]               awid,
    input  logic [ADDR_W-1:0]             awaddr,
    input  logic [BLEN_W-1:0]             awlen,
    input  logic [SIZE_W-1:0]             awsize,
    // W channel
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [8*DATA_BYTES-1:0]       wdata,
    input  logic [DATA_BYTES-1:0]         wstrb,
    input  logic                          wlast,
    // B channel
    output logic                          bvalid,
    input  logic                          bready,
    output logic [ID_W-1:0]               bid,
    output logic [1:0]                    bresp,
    // data FIFO
    output logic                          pkt_wr,
    output logic [8*DATA_BYTES-1:0]       pkt_data,
    output logic                          pkt_sop,
    output logic                          pkt_eop,
    output logic [$clog2(DATA_BYTES)-1:0] pkt_mod,
    output logic [CHAN_W-1:0]             pkt_chan,
    input  logic                          pkt_full,
    // command FIFO
    output logic                          cmd_wr,
    output pkt_cmd_t                      cmd_data,
    input  logic                          cmd_full
);

    logic                          beat_fire;
    logic                          beat_last;
    logic [CHAN_W-1:0]             chan;
    logic                          last_done;
    logic [$clog2(DATA_BYTES)-1:0] last_mod;

    burst_info_if info ();

    axi_wr_ctrl u_ctrl (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .awvalid   (awvalid),
        .awready   (awready),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .wvalid    (wvalid),
        .wready    (wready),
        .wlast     (wlast),
        .bvalid    (bvalid),
        .bready    (bready),
        .bid       (bid),
        .bresp     (bresp),
        .pkt_full  (pkt_full),
        .cmd_full  (cmd_full),
        .beat_fire (beat_fire),
        .beat_last (beat_last),
        .chan      (chan),
        .info      (info.master)
    );

    beat_pack #(
        .DATA_BYTES (DATA_BYTES)
    ) u_pack (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .beat_fire (beat_fire),
        .beat_last (beat_last),
        .chan      (chan),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .pkt_wr    (pkt_wr),
        .pkt_data  (pkt_data),
        .pkt_sop   (pkt_sop),
        .pkt_eop   (pkt_eop),
        .pkt_mod   (pkt_mod),
        .pkt_chan  (pkt_chan),
        .last_done (last_done),
        .last_mod  (last_mod)
    );

    pkt_cmd_gen #(
        .DATA_BYTES (DATA_BYTES)
    ) u_cmd (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .last_done (last_done),
        .last_mod  (last_mod),
        .cmd_wr    (cmd_wr),
        .cmd_data  (cmd_data),
        .info      (info.slave)
    );

endmodule

// ==== axi_wr_testdata.txt ====
// awid awaddr awlen awsize last_wstrb full_sel full_cycles bready_delay, all hex
// full_sel bit 0 drives pkt_full, bit 1 drives cmd_full
3 00001000 03 3 ff 0 0 0
a 00002005 00 3 01 0 0 2
5 0000300a 07 3 0f 1 5 0
c 0000400c 02 3 a5 2 3 4
f 80000003 0f 3 7f 3 2 1
0 00005fff 01 3 03 0 0 0
7 00006006 05 2 3f 1 1 3
9 12345679 1f 3 ff 2 6 0
1 0000a00e 00 3 ff 0 0 5
6 0000b001 04 1 81 3 4 2

// ==== beat_pack.sv ====
//**************************************************************************
// W beat to packet word stage
// sop/eop marking, channel id and empty byte count from the strobe
//**************************************************************************

`timescale 1ns/1ps

module beat_pack
    import axi_wr_pkg::*;
#(
    parameter int DATA_BYTES = 8,
    localparam int MOD_W = $clog2(DATA_BYTES)
) (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    beat_fire,
    input  logic                    beat_last,
    input  logic [CHAN_W-1:0]       chan,
    input  logic [8*DATA_BYTES-1:0] wdata,
    input  logic [DATA_BYTES-1:0]   wstrb,
    // data FIFO write side
    output logic                    pkt_wr,
    output logic [8*DATA_BYTES-1:0] pkt_data,
    output logic                    pkt_sop,
    output logic                    pkt_eop,
    output logic [MOD_W-1:0]        pkt_mod,
    output logic [CHAN_W-1:0]       pkt_chan,
    // to the command stage
    output logic                    last_done,
    output logic [MOD_W-1:0]        last_mod
);

    logic [8*DATA_BYTES-1:0] wdata_q;
    logic [DATA_BYTES-1:0]   wstrb_q;
    logic                    in_pkt;

    // empty bytes above a low-aligned strobe run, anything else gives 0
    function automatic logic [MOD_W-1:0] strb_mod(input logic [DATA_BYTES-1:0] strb);
        logic [MOD_W-1:0] m;
        m = '0;
        for (int k = 1; k < DATA_BYTES; k++) begin
            if (strb == ({DATA_BYTES{1'b1}} >> (DATA_BYTES - k))) begin
                m = MOD_W'(DATA_BYTES - k);
            end
        end
        return m;
    endfunction

    // bus sample at the handshake edge, beat_fire arrives one cycle later
    always_ff @(posedge clk_sys) begin
        wdata_q <= wdata;
        wstrb_q <= wstrb;
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            pkt_wr  <= 1'b0;
            pkt_sop <= 1'b0;
            pkt_eop <= 1'b0;
            in_pkt  <= 1'b0;
        end else begin
            pkt_wr  <= beat_fire;
            pkt_sop <= beat_fire && !in_pkt;
            pkt_eop <= beat_fire && beat_last;
            if (beat_fire) begin
                in_pkt <= !beat_last;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (beat_fire) begin
            pkt_data <= wdata_q;
            pkt_mod  <= strb_mod(wstrb_q);
            pkt_chan <= chan;
        end
    end

    assign last_done = pkt_wr && pkt_eop;
    assign last_mod  = pkt_mod;

endmodule

// ==== burst_info_if.sv ====
//**************************************************************************
// burst field bundle from the write controller to the command stage
//**************************************************************************

`timescale 1ns/1ps

interface burst_info_if
    import axi_wr_pkg::*;
();

    // one cycle pulse after AW acceptance
    logic              fire;
    logic [ID_W-1:0]   id;
    logic [BLEN_W-1:0] blen;
    logic [SIZE_W-1:0] size;
    logic [ADDR_W-1:0] addr;

    modport master (
        output fire, id, blen, size, addr
    );

    modport slave (
        input fire, id, blen, size, addr
    );

endinterface

// ==== filelist.f ====
axi_wr_pkg.sv
burst_info_if.sv
axi_wr_ctrl.sv
beat_pack.sv
pkt_cmd_gen.sv
axi_wr_pkt_top.sv
tb_clkgen.sv
tb_axi_wr_pkt_assert.sv
tb_axi_wr_pkt.sv

// ==== pkt_cmd_gen.sv ====
//**************************************************************************
// command word builder
// burst fields plus packet length in bytes, one write per burst
//**************************************************************************

`timescale 1ns/1ps

module pkt_cmd_gen
    import axi_wr_pkg::*;
#(
    parameter int DATA_BYTES = 8,
    localparam int MOD_W = $clog2(DATA_BYTES)
) (
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             last_done,
    input  logic [MOD_W-1:0] last_mod,
    output logic             cmd_wr,
    output pkt_cmd_t         cmd_data,
    burst_info_if.slave      info
);

    logic [ID_W-1:0]      id_q;
    logic [BLEN_W-1:0]    blen_q;
    logic [SIZE_W-1:0]    size_q;
    logic [ADDR_W-1:0]    addr_q;
    logic [PKT_LEN_W-1:0] pkt_len;

    // hold this burst's fields, the controller may move on before the command
    always_ff @(posedge clk_sys) begin
        if (info.fire) begin
            id_q   <= info.id;
            blen_q <= info.blen;
            size_q <= info.size;
            addr_q <= info.addr;
        end
    end

    // beats times bytes per beat, less the empty bytes of the last beat
    assign pkt_len = (PKT_LEN_W'(blen_q) + 1'b1) * PKT_LEN_W'(DATA_BYTES)
                   - PKT_LEN_W'(last_mod);

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            cmd_wr <= 1'b0;
        end else begin
            cmd_wr <= last_done;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (last_done) begin
            cmd_data.id      <= id_q;
            cmd_data.blen    <= blen_q;
            cmd_data.size    <= size_q;
            cmd_data.addr    <= addr_q;
            cmd_data.pkt_len <= pkt_len;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the AXI write packet bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_axi_wr_pkt -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"
echo "$out" | grep -qx "Testbench passed"

// ==== tb_axi_wr_pkt.sv ====
//**************************************************************************
// testbench for the AXI4 write to packet FIFO bridge
// AXI master driver from a stimulus file, FIFO side monitor
// expected packet and command words, response checks, watchdog
//**************************************************************************

`timescale 1ns/1ps

module tb_axi_wr_pkt
    import axi_wr_pkg::*;
();

    localparam int DATA_BYTES = 8;
    localparam int MOD_W      = $clog2(DATA_BYTES);
    localparam int RST_CYCLES = 16;
    localparam int MAX_BURSTS = 64;

    logic                    clk_sys;
    logic                    rst;
    logic                    awvalid;
    logic                    awready;
    logic [ID_W-1:0]         awid;
    logic [ADDR_W-1:0]       awaddr;
    logic [BLEN_W-1:0]       awlen;
    logic [SIZE_W-1:0]       awsize;
    logic                    wvalid;
    logic                    wready;
    logic [8*DATA_BYTES-1:0] wdata;
    logic [DATA_BYTES-1:0]   wstrb;
    logic                    wlast;
    logic                    bvalid;
    logic                    bready;
    logic [ID_W-1:0]         bid;
    logic [1:0]              bresp;
    logic                    pkt_wr;
    logic [8*DATA_BYTES-1:0] pkt_data;
    logic                    pkt_sop;
    logic                    pkt_eop;
    logic [MOD_W-1:0]        pkt_mod;
    logic [CHAN_W-1:0]       pkt_chan;
    logic                    pkt_full;
    logic                    cmd_wr;
    pkt_cmd_t                cmd_data;
    logic                    cmd_full;

    typedef struct packed {
        logic [8*DATA_BYTES-1:0] data;
        logic                    sop;
        logic                    eop;
        logic [MOD_W-1:0]        mod;
        logic [CHAN_W-1:0]       chan;
    } word_t;

    // one entry per burst line of the stimulus file
    logic [ID_W-1:0]       st_id   [0:MAX_BURSTS-1];
    logic [ADDR_W-1:0]     st_addr [0:MAX_BURSTS-1];
    logic [BLEN_W-1:0]     st_len  [0:MAX_BURSTS-1];
    logic [SIZE_W-1:0]     st_size [0:MAX_BURSTS-1];
    logic [DATA_BYTES-1:0] st_strb [0:MAX_BURSTS-1];
    logic [1:0]            st_fsel [0:MAX_BURSTS-1];
    int                    st_fcyc [0:MAX_BURSTS-1];
    int                    st_dly  [0:MAX_BURSTS-1];

    word_t    exp_words[$];
    pkt_cmd_t exp_cmds[$];
    word_t    mon_word;
    integer   seed = 32'hcb74_a241;
    int       n_bursts;
    int       eop_cnt;
    int       cmd_cnt;
    int       limit_cycles;
    logic     limit_set;
    logic     run_over;

    tb_clkgen #(
        .PERIOD_NS  (20),
        .RST_CYCLES (RST_CYCLES)
    ) u_clkgen (
        .clk_sys (clk_sys),
        .rst     (rst)
    );

    axi_wr_pkt_top #(
        .DATA_BYTES (DATA_BYTES)
    ) DUT (.*);

    //**********************************************************************
    // reporting and compare tasks
    //**********************************************************************
    task automatic fail_stop(input string msg);
        run_over = 1'b1;
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic string value_error(input string name,
                                          input logic [8*DATA_BYTES-1:0] exp,
                                          input logic [8*DATA_BYTES-1:0] got);
        return $sformatf("Error at %0d ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    endfunction

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) fail_stop(value_error(name, exp, got));
    endtask

    task automatic check_word(input word_t exp, input word_t got);
        if (got.data !== exp.data) fail_stop(value_error("pkt_data", exp.data, got.data));
        if (got.sop !== exp.sop) fail_stop(value_error("pkt_sop", exp.sop, got.sop));
        if (got.eop !== exp.eop) fail_stop(value_error("pkt_eop", exp.eop, got.eop));
        if (got.mod !== exp.mod) fail_stop(value_error("pkt_mod", exp.mod, got.mod));
        if (got.chan !== exp.chan) fail_stop(value_error("pkt_chan", exp.chan, got.chan));
    endtask

    task automatic check_cmd(input pkt_cmd_t exp, input pkt_cmd_t got);
        if (got.id !== exp.id) fail_stop(value_error("cmd_data.id", exp.id, got.id));
        if (got.blen !== exp.blen) fail_stop(value_error("cmd_data.blen", exp.blen, got.blen));
        if (got.size !== exp.size) fail_stop(value_error("cmd_data.size", exp.size, got.size));
        if (got.addr !== exp.addr) fail_stop(value_error("cmd_data.addr", exp.addr, got.addr));
        if (got.pkt_len !== exp.pkt_len) begin
            fail_stop(value_error("cmd_data.pkt_len", exp.pkt_len, got.pkt_len));
        end
    endtask

    task automatic check_resp(input logic [ID_W-1:0] exp_id, input logic [1:0] exp_resp,
                              input logic [ID_W-1:0] got_id, input logic [1:0] got_resp);
        if (got_id !== exp_id) fail_stop(value_error("bid", exp_id, got_id));
        if (got_resp !== exp_resp) fail_stop(value_error("bresp", exp_resp, got_resp));
    endtask

    // bytes left empty above a run of strobes starting at byte 0
    function automatic logic [MOD_W-1:0] empty_bytes(input logic [DATA_BYTES-1:0] strb);
        int ones;
        logic [MOD_W-1:0] res;
        ones = 0;
        res  = '0;
        while (ones < DATA_BYTES && strb[ones]) ones++;
        if (ones > 0 && (strb >> ones) == '0) res = MOD_W'(DATA_BYTES - ones);
        return res;
    endfunction

    //**********************************************************************
    // stimulus file
    //**********************************************************************
    task automatic read_stimulus();
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [31:0]      f [0:7];
        fd = $fopen("axi_wr_testdata.txt", "r");
        if (fd == 0) begin
            fail_stop("cannot open the stimulus file axi_wr_testdata.txt");
        end else begin
            n_bursts     = 0;
            limit_cycles = RST_CYCLES;
            while (!$feof(fd) && n_bursts < MAX_BURSTS) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n == 8) begin
                    st_id[n_bursts]   = f[0][ID_W-1:0];
                    st_addr[n_bursts] = f[1][ADDR_W-1:0];
                    st_len[n_bursts]  = f[2][BLEN_W-1:0];
                    st_size[n_bursts] = f[3][SIZE_W-1:0];
                    st_strb[n_bursts] = f[4][DATA_BYTES-1:0];
                    st_fsel[n_bursts] = f[5][1:0];
                    st_fcyc[n_bursts] = int'(f[6]);
                    st_dly[n_bursts]  = int'(f[7]);
                    limit_cycles += 10 * (int'(f[2][BLEN_W-1:0]) + 1 + int'(f[6]) + int'(f[7]));
                    n_bursts++;
                end
            end
            $fclose(fd);
            if (n_bursts == 0) fail_stop("no burst lines found in axi_wr_testdata.txt");
            limit_set = 1'b1;
        end
    endtask

    //**********************************************************************
    // AXI master, one burst from AW to B
    //**********************************************************************
    task automatic run_burst(input int b);
        word_t    w;
        pkt_cmd_t c;
        int       n_beats;
        n_beats = int'(st_len[b]) + 1;
        // FIFO full before the burst, AW must be held off
        if (st_fcyc[b] > 0) begin
            pkt_full = st_fsel[b][0];
            cmd_full = st_fsel[b][1];
            @(negedge clk_sys);
        end
        awvalid = 1'b1;
        awid    = st_id[b];
        awaddr  = st_addr[b];
        awlen   = st_len[b];
        awsize  = st_size[b];
        for (int i = 0; i < st_fcyc[b]; i++) begin
            check_flag("awready", 1'b0, awready);
            @(negedge clk_sys);
        end
        pkt_full = 1'b0;
        cmd_full = 1'b0;
        c.id      = st_id[b];
        c.blen    = st_len[b];
        c.size    = st_size[b];
        c.addr    = st_addr[b];
        c.pkt_len = PKT_LEN_W'(n_beats * DATA_BYTES - int'(empty_bytes(st_strb[b])));
        exp_cmds.push_back(c);
        while (!awready) @(negedge clk_sys);
        @(negedge clk_sys);
        awvalid = 1'b0;
        for (int beat = 0; beat < n_beats; beat++) begin
            // an idle cycle now and then inside the burst
            if (($random(seed) & 3) == 0) begin
                wvalid = 1'b0;
                @(negedge clk_sys);
            end
            for (int k = 0; k < DATA_BYTES / 4; k++) wdata[32*k +: 32] = $random(seed);
            wstrb  = (beat == n_beats - 1) ? st_strb[b] : '1;
            wlast  = (beat == n_beats - 1);
            wvalid = 1'b1;
            w.data = wdata;
            w.sop  = (beat == 0);
            w.eop  = wlast;
            w.mod  = empty_bytes(wstrb);
            w.chan = st_addr[b][CHAN_W-1:0];
            exp_words.push_back(w);
            while (!wready) @(negedge clk_sys);
            @(negedge clk_sys);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        while (!bvalid) @(negedge clk_sys);
        for (int i = 0; i < st_dly[b]; i++) begin
            check_flag("bvalid", 1'b1, bvalid);
            @(negedge clk_sys);
        end
        bready = 1'b1;
        check_resp(st_id[b], 2'b00, bid, bresp);
        @(negedge clk_sys);
        bready = 1'b0;
        check_flag("awready", 1'b1, awready);
    endtask

    //**********************************************************************
    // FIFO side monitor
    //**********************************************************************
    always @(negedge clk_sys) begin
        if (pkt_wr) begin
            mon_word = {pkt_data, pkt_sop, pkt_eop, pkt_mod, pkt_chan};
            if (exp_words.size() == 0) begin
                fail_stop("packet word written with no W beat outstanding");
            end else begin
                check_word(exp_words.pop_front(), mon_word);
                if (pkt_eop) eop_cnt++;
            end
        end
        if (cmd_wr) begin
            if (exp_cmds.size() == 0) begin
                fail_stop("command word written with no burst outstanding");
            end else if (eop_cnt <= cmd_cnt) begin
                fail_stop("command word written before the eop word of its burst");
            end else begin
                check_cmd(exp_cmds.pop_front(), cmd_data);
                cmd_cnt++;
            end
        end
    end

    initial begin
        wait (limit_set);
        repeat (limit_cycles) @(posedge clk_sys);
        fail_stop($sformatf("watchdog timeout after %0d cycles", limit_cycles));
    end

    initial begin
        awvalid   = 1'b0;
        awid      = '0;
        awaddr    = '0;
        awlen     = '0;
        awsize    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wlast     = 1'b0;
        bready    = 1'b0;
        pkt_full  = 1'b0;
        cmd_full  = 1'b0;
        eop_cnt   = 0;
        cmd_cnt   = 0;
        limit_set = 1'b0;
        run_over  = 1'b0;
        read_stimulus();
        @(negedge rst);
        @(negedge clk_sys);
        check_flag("awready", 1'b1, awready);
        check_flag("wready", 1'b0, wready);
        check_flag("bvalid", 1'b0, bvalid);
        check_flag("pkt_wr", 1'b0, pkt_wr);
        check_flag("cmd_wr", 1'b0, cmd_wr);
        for (int b = 0; b < n_bursts; b++) run_burst(b);
        while (exp_words.size() != 0 || exp_cmds.size() != 0) @(negedge clk_sys);
        repeat (4) @(negedge clk_sys);
        if (eop_cnt == n_bursts && cmd_cnt == n_bursts) begin
            run_over = 1'b1;
            $display("Testbench passed");
            $finish;
        end else begin
            fail_stop("packet or command count does not match the number of bursts");
        end
    end

    // Run stopped early, e.g. by an assertion.
    final begin
        if (!run_over) $display("Testbench failed");
    end

endmodule

// ==== tb_axi_wr_pkt_assert.sv ====
//**************************************************************************
// concurrent protocol checks on the write controller
// AW/W exclusion, B hold until bready, W beats only in RECV
//**************************************************************************

`timescale 1ns/1ps

module tb_axi_wr_pkt_assert
    import axi_wr_pkg::*;
(
    input logic      clk_sys,
    input logic      rst,
    input logic      awready,
    input logic      wvalid,
    input logic      wready,
    input logic      bvalid,
    input logic      bready,
    input wr_state_e state
);

    // address and data phases never open together
    a_aw_w_excl: assert property (@(posedge clk_sys) disable iff (rst)
        !(awready && wready))
        else $error("awready and wready high in the same cycle");

    a_b_hold: assert property (@(posedge clk_sys) disable iff (rst)
        (bvalid && !bready) |=> bvalid)
        else $error("bvalid dropped before bready");

    // a beat is only taken while receiving
    a_w_in_recv: assert property (@(posedge clk_sys) disable iff (rst)
        (wvalid && wready) |-> (state == RECV))
        else $error("W beat accepted outside RECV");

endmodule

bind axi_wr_ctrl tb_axi_wr_pkt_assert u_assert (
    .clk_sys (clk_sys),
    .rst     (rst),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .state   (state)
);

// ==== tb_clkgen.sv ====
//**************************************************************************
// testbench clock and reset generator
// 20 ns clock, reset held for a fixed number of cycles
//**************************************************************************

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 16
) (
    output logic clk_sys,
    output logic rst
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
    end

    // release on a falling edge, away from the DUT clock edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
    end

endmodule
